// File: files.f
+incdir+sim
logic/tcb_pkg.sv
logic/tcb_if.sv
logic/tcb_register_request.sv
logic/tcb_sram.sv
logic/tcb_protect_regs.sv
logic/tcb_mem_top.sv
sim/tcb_mem_tb.sv

// File: logic/tcb_if.sv
// tcb interface
// request, response and handshake signals with manager and device views

`default_nettype none

interface tcb_if #(
  parameter int unsigned ABW = tcb_pkg::TCB_ABW,
  parameter int unsigned DBW = tcb_pkg::TCB_DBW,
  parameter int unsigned DLY = 1
)(
  input wire sub,
  input wire rst_n
);

  import tcb_pkg::*;

  // byte enable width follows the data width
  localparam int unsigned BEW = DBW / 8;

  // handshake
  logic           vld;
  logic           rdy;

  // request
  logic           wen;
  tcb_siz_e       siz;
  logic [ABW-1:0] adr;
  logic [BEW-1:0] ben;
  logic [DBW-1:0] wdt;

  // response, valid DLY edges after the transfer
  logic [DBW-1:0] rdt;
  logic           err;

  // manager side drives the request
  modport man (
    input  sub, rst_n,
    output vld, wen, siz, adr, ben, wdt,
    input  rdy, rdt, err
  );

  // device side answers it
  modport dev (
    input  sub, rst_n,
    input  vld, wen, siz, adr, ben, wdt,
    output rdy, rdt, err
  );

endinterface : tcb_if

`default_nettype wire

// File: logic/tcb_mem_top.sv
// tcb memory subsystem top level
// request slice, memory and protection registers behind plain tcb and axi4-lite ports

`default_nettype none

module tcb_mem_top #(
  parameter int unsigned ABW = tcb_pkg::TCB_ABW,
  parameter int unsigned DBW = tcb_pkg::TCB_DBW,
  parameter int unsigned GRN = tcb_pkg::TCB_GRN
)(
  input  wire                          sub,
  input  wire                          rst_n,
  // tcb request
  input  wire                          vld,
  output logic                         rdy,
  input  wire                          wen,
  input  wire  tcb_pkg::tcb_siz_e      siz,
  input  wire  [ABW-1:0]               adr,
  input  wire  [DBW/8-1:0]             ben,
  input  wire  [DBW-1:0]               wdt,
  // tcb response, two cycles after the transfer
  output logic [DBW-1:0]               rdt,
  output logic                         err,
  // axi4-lite configuration port
  input  wire  [tcb_pkg::CFG_AW-1:0]   awaddr,
  input  wire                          awvalid,
  output logic                         awready,
  input  wire  [tcb_pkg::CFG_DW-1:0]   wdata,
  input  wire  [tcb_pkg::CFG_DW/8-1:0] wstrb,
  input  wire                          wvalid,
  output logic                         wready,
  output tcb_pkg::axi_resp_e           bresp,
  output logic                         bvalid,
  input  wire                          bready,
  input  wire  [tcb_pkg::CFG_AW-1:0]   araddr,
  input  wire                          arvalid,
  output logic                         arready,
  output logic [tcb_pkg::CFG_DW-1:0]   rdata,
  output tcb_pkg::axi_resp_e           rresp,
  output logic                         rvalid,
  input  wire                          rready
);

  logic [ABW-1:0] prot_limit;
  logic           prot_en;
  logic           refused;

  // port side bus and slice to memory bus
  tcb_if #(.ABW(ABW), .DBW(DBW), .DLY(2)) tcb_up (.sub(sub), .rst_n(rst_n));
  tcb_if #(.ABW(ABW), .DBW(DBW), .DLY(1)) tcb_dn (.sub(sub), .rst_n(rst_n));

  // plain ports onto the upstream bus
  assign tcb_up.vld = vld;
  assign tcb_up.wen = wen;
  assign tcb_up.siz = siz;
  assign tcb_up.adr = adr;
  assign tcb_up.ben = ben;
  assign tcb_up.wdt = wdt;
  assign rdy        = tcb_up.rdy;
  assign rdt        = tcb_up.rdt;
  assign err        = tcb_up.err;

  tcb_register_request #(.GRN(GRN)) slice_i (
    .up (tcb_up),
    .dn (tcb_dn)
  );

  tcb_sram #(.ABW(ABW), .DBW(DBW)) sram_i (
    .bus        (tcb_dn),
    .prot_limit (prot_limit),
    .prot_en    (prot_en),
    .refused    (refused)
  );

  tcb_protect_regs #(.ABW(ABW)) regs_i (
    .sub        (sub),
    .rst_n      (rst_n),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .refused    (refused),
    .prot_limit (prot_limit),
    .prot_en    (prot_en)
  );

endmodule : tcb_mem_top

`default_nettype wire

// File: logic/tcb_pkg.sv
// tcb memory subsystem shared definitions
// transfer sizes, axi4-lite response codes, config register map and width defaults

`default_nettype none

package tcb_pkg;

  //////////////////////////////////////////////////
  // width defaults
  //////////////////////////////////////////////////

  // tcb address width in bits (byte address)
  parameter int unsigned TCB_ABW = 12;
  // tcb data width in bits
  parameter int unsigned TCB_DBW = 32;
  // slice hold granularity in bytes
  parameter int unsigned TCB_GRN = 1;

  // config port address width, covers the whole register map
  parameter int unsigned CFG_AW = 4;
  // config port data width
  parameter int unsigned CFG_DW = 32;

  //////////////////////////////////////////////////
  // enumerations
  //////////////////////////////////////////////////

  // transfer size as log2 of the byte count
  typedef enum logic [1:0] {
    SIZ_BYTE = 2'd0,
    SIZ_HALF = 2'd1,
    SIZ_WORD = 2'd2
  } tcb_siz_e;

  // axi4-lite response codes
  // exokay and decerr never produced here
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // config register byte addresses
  typedef enum logic [CFG_AW-1:0] {
    REG_LIMIT  = 4'h0,
    REG_CTRL   = 4'h4,
    REG_ERRCNT = 4'h8
  } cfg_reg_e;

endpackage : tcb_pkg

`default_nettype wire

// File: logic/tcb_protect_regs.sv
// memory protection register block
// axi4-lite slave holding the write limit, the enable bit and a refused request counter

`default_nettype none

module tcb_protect_regs #(
  parameter int unsigned ABW = tcb_pkg::TCB_ABW
)(
  input  wire                         sub,
  input  wire                         rst_n,
  // write address
  input  wire  [tcb_pkg::CFG_AW-1:0]  awaddr,
  input  wire                         awvalid,
  output logic                        awready,
  // write data
  input  wire  [tcb_pkg::CFG_DW-1:0]  wdata,
  input  wire  [tcb_pkg::CFG_DW/8-1:0] wstrb,
  input  wire                         wvalid,
  output logic                        wready,
  // write response
  output tcb_pkg::axi_resp_e          bresp,
  output logic                        bvalid,
  input  wire                         bready,
  // read address
  input  wire  [tcb_pkg::CFG_AW-1:0]  araddr,
  input  wire                         arvalid,
  output logic                        arready,
  // read data
  output logic [tcb_pkg::CFG_DW-1:0]  rdata,
  output tcb_pkg::axi_resp_e          rresp,
  output logic                        rvalid,
  input  wire                         rready,
  // memory side
  input  wire                         refused,
  output logic [ABW-1:0]              prot_limit,
  output logic                        prot_en
);

  import tcb_pkg::*;

  // the limit has to fit a config word
  if (ABW > CFG_DW) begin : g_chk_abw
    $error("ABW %0d wider than the config data width %0d", ABW, CFG_DW);
  end

  logic              wr_go;
  logic              rd_go;
  logic              wr_lim;
  logic              wr_ctl;
  logic              wr_bad;
  logic [CFG_DW-1:0] lim_new;
  logic [CFG_DW-1:0] rd_val;
  logic              rd_bad;
  logic [CFG_DW-1:0] errcnt;

  //////////////////////////////////////////////////
  // handshakes
  //////////////////////////////////////////////////

  // aw and w are taken together, and only with no response pending
  assign wr_go   = awvalid & wvalid & ~bvalid;
  assign awready = wr_go;
  assign wready  = wr_go;

  // one read in flight
  assign arready = ~rvalid;
  assign rd_go   = arvalid & arready;

  //////////////////////////////////////////////////
  // write decode
  //////////////////////////////////////////////////

  always_comb begin
    wr_lim = 1'b0;
    wr_ctl = 1'b0;
    wr_bad = 1'b0;
    case (cfg_reg_e'(awaddr))
      REG_LIMIT: wr_lim = 1'b1;
      REG_CTRL:  wr_ctl = 1'b1;
      // counter is read only, unmapped falls here too
      default:   wr_bad = 1'b1;
    endcase
  end

  // merge strobed bytes into the current limit
  always_comb begin
    lim_new = CFG_DW'(prot_limit);
    for (int unsigned b = 0; b < CFG_DW / 8; b++) begin
      if (wstrb[b]) begin
        lim_new[8*b +: 8] = wdata[8*b +: 8];
      end
    end
  end

  //////////////////////////////////////////////////
  // read decode
  //////////////////////////////////////////////////

  always_comb begin
    rd_bad = 1'b0;
    case (cfg_reg_e'(araddr))
      REG_LIMIT:  rd_val = CFG_DW'(prot_limit);
      REG_CTRL:   rd_val = CFG_DW'(prot_en);
      REG_ERRCNT: rd_val = errcnt;
      default: begin
        rd_val = '0;
        rd_bad = 1'b1;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      prot_limit <= '1;
      prot_en    <= 1'b0;
      errcnt     <= '0;
      bvalid     <= 1'b0;
      rvalid     <= 1'b0;
    end else begin
      // programmable fields
      if (wr_go && wr_lim) begin
        prot_limit <= lim_new[ABW-1:0];
      end
      if (wr_go && wr_ctl && wstrb[0]) begin
        prot_en <= wdata[0];
      end
      // saturating count of refused requests
      if (refused && (errcnt != '1)) begin
        errcnt <= errcnt + 1'b1;
      end
      // response valids, held until taken
      if (wr_go) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rd_go) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // response payloads
  always_ff @(posedge sub) begin
    if (wr_go) begin
      bresp <= wr_bad ? RESP_SLVERR : RESP_OKAY;
    end
    if (rd_go) begin
      rdata <= rd_val;
      rresp <= rd_bad ? RESP_SLVERR : RESP_OKAY;
    end
  end

  // write response stays put until the manager takes it
  a_bvalid_hold : assert property (
    @(posedge sub) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp)
  );

endmodule : tcb_protect_regs

`default_nettype wire

// File: logic/tcb_register_request.sv
// tcb request path register slice
// registers every request once, adding one cycle to the response delay

`default_nettype none

module tcb_register_request #(
  parameter int unsigned GRN = tcb_pkg::TCB_GRN
)(
  tcb_if.dev up,
  tcb_if.man dn
);

  // byte lanes on the bus
  localparam int unsigned BEW = up.BEW;

  //////////////////////////////////////////////////
  // elaboration checks
  //////////////////////////////////////////////////

  // both sides must carry the same bus shape
  if (up.ABW != dn.ABW) begin : g_chk_abw
    $error("up.ABW %0d differs from dn.ABW %0d", up.ABW, dn.ABW);
  end
  if (up.DBW != dn.DBW) begin : g_chk_dbw
    $error("up.DBW %0d differs from dn.DBW %0d", up.DBW, dn.DBW);
  end
  if (up.BEW != dn.BEW) begin : g_chk_bew
    $error("up.BEW %0d differs from dn.BEW %0d", up.BEW, dn.BEW);
  end
  // the slice adds exactly one cycle
  if (up.DLY != dn.DLY + 1) begin : g_chk_dly
    $error("up.DLY %0d is not dn.DLY %0d plus one", up.DLY, dn.DLY);
  end
  // lanes must tile the byte enables
  if ((GRN == 0) || (BEW % GRN != 0)) begin : g_chk_grn
    $error("GRN %0d does not divide the byte enable width %0d", GRN, BEW);
  end

  //////////////////////////////////////////////////
  // request register
  //////////////////////////////////////////////////

  // valid moves forward whenever the slice can take a new request
  always_ff @(posedge up.sub or negedge up.rst_n) begin
    if (!up.rst_n) begin
      dn.vld <= 1'b0;
    end else if (up.rdy) begin
      dn.vld <= up.vld;
    end
  end

  // request fields, held while downstream stalls
  always_ff @(posedge up.sub) begin
    if (up.rdy) begin
      dn.wen <= up.wen;
      dn.siz <= up.siz;
      dn.adr <= up.adr;
      dn.ben <= up.ben;
      // write data per lane, only lanes that a write enables
      for (int unsigned i = 0; i < BEW; i += GRN) begin
        if (up.wen && (|up.ben[i +: GRN])) begin
          dn.wdt[8*i +: 8*GRN] <= up.wdt[8*i +: 8*GRN];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // response and ready
  //////////////////////////////////////////////////

  // response returns untouched
  assign up.rdt = dn.rdt;
  assign up.err = dn.err;

  // an empty register accepts even when downstream is busy
  assign up.rdy = dn.rdy | ~dn.vld;

  // downstream valid must be a clean level once out of reset
  a_dn_vld_known : assert property (
    @(posedge up.sub) disable iff (!up.rst_n)
    !$isunknown(dn.vld)
  );

endmodule : tcb_register_request

`default_nettype wire

// File: logic/tcb_sram.sv
// tcb subordinate memory
// byte enable writes, one cycle read latency, refuses protected and misaligned requests

`default_nettype none

module tcb_sram #(
  parameter int unsigned ABW = tcb_pkg::TCB_ABW,
  parameter int unsigned DBW = tcb_pkg::TCB_DBW
)(
  tcb_if.dev              bus,
  input  wire [ABW-1:0]   prot_limit,
  input  wire             prot_en,
  output logic            refused
);

  import tcb_pkg::*;

  localparam int unsigned BEW = DBW / 8;
  // byte offset bits inside a word
  localparam int unsigned BOW = $clog2(BEW);
  // number of words
  localparam int unsigned DEP = 2 ** (ABW - BOW);

  //////////////////////////////////////////////////
  // elaboration checks
  //////////////////////////////////////////////////

  if ((bus.ABW != ABW) || (bus.DBW != DBW)) begin : g_chk_width
    $error("bus widths %0d/%0d differ from ABW %0d DBW %0d", bus.ABW, bus.DBW, ABW, DBW);
  end
  // response is registered once
  if (bus.DLY != 1) begin : g_chk_dly
    $error("bus.DLY %0d but the memory answers after one cycle", bus.DLY);
  end

  //////////////////////////////////////////////////
  // request decode
  //////////////////////////////////////////////////

  logic [DBW-1:0]     mem [DEP];
  logic [ABW-BOW-1:0] idx;
  logic               trn;
  logic               misal;
  logic               prot_hit;
  logic               deny;

  // never stalls
  assign bus.rdy = 1'b1;

  assign trn = bus.vld & bus.rdy;
  assign idx = bus.adr[ABW-1:BOW];

  // address must be aligned to the transfer size
  always_comb begin
    case (bus.siz)
      SIZ_BYTE: misal = 1'b0;
      SIZ_HALF: misal = bus.adr[0];
      SIZ_WORD: misal = |bus.adr[1:0];
      default:  misal = 1'b1;
    endcase
  end

  // protection applies to writes only
  assign prot_hit = prot_en & bus.wen & (bus.adr >= prot_limit);
  assign deny     = prot_hit | misal;

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  // write enabled bytes, refused writes leave memory alone
  always_ff @(posedge bus.sub) begin
    if (trn && bus.wen && !deny) begin
      for (int unsigned b = 0; b < BEW; b++) begin
        if (bus.ben[b]) begin
          mem[idx][8*b +: 8] <= bus.wdt[8*b +: 8];
        end
      end
    end
  end

  // full word read, byte selection is up to the manager
  always_ff @(posedge bus.sub) begin
    if (trn && !bus.wen) begin
      bus.rdt <= mem[idx];
    end
  end

  //////////////////////////////////////////////////
  // error response
  //////////////////////////////////////////////////

  always_ff @(posedge bus.sub or negedge bus.rst_n) begin
    if (!bus.rst_n) begin
      bus.err <= 1'b0;
    end else begin
      bus.err <= trn & deny;
    end
  end

  // refused pulse lines up with err
  assign refused = bus.err;

  // err only answers a transfer one cycle earlier
  a_err_has_transfer : assert property (
    @(posedge bus.sub) disable iff (!bus.rst_n)
    bus.err |-> $past(bus.vld && bus.rdy)
  );

endmodule : tcb_sram

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the tcb memory subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module tcb_mem_tb \
  -Mdir obj_dir -o tcb_mem_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tcb_mem_sim > "$SIM_LOG" 2>&1
rc=$?
cat "$SIM_LOG"
if [ $rc -ne 0 ]; then
  echo "simulation exited with status $rc"
  exit 1
fi

if grep -q '\*\* FAIL \*\*' "$SIM_LOG"; then
  exit 1
fi
exit 0

// File: sim/tcb_mem_tb_tasks.svh
// testbench helpers for the tcb memory subsystem
// lfsr, tcb and axi4-lite drivers and typed compare tasks

`ifndef TCB_MEM_TB_TASKS_SVH
`define TCB_MEM_TB_TASKS_SVH

//////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////

task automatic check_rdt(input logic [DBW-1:0] got, input logic [DBW-1:0] exp,
                         input int unsigned n);
  if (got !== exp) begin
    rdt_errs++;
    $display("MISMATCH at %0t: entry %0d rdt %h, expected %h", $time, n, got, exp);
  end
endtask

task automatic check_err(input logic got, input logic exp, input int unsigned n);
  if (got !== exp) begin
    err_errs++;
    $display("MISMATCH at %0t: entry %0d err %b, expected %b", $time, n, got, exp);
  end
endtask

task automatic check_ready(input logic got, input logic exp, input string name,
                           input int unsigned n);
  if (got !== exp) begin
    rdy_errs++;
    $display("MISMATCH at %0t: entry %0d %s %b, expected %b", $time, n, name, got, exp);
  end
endtask

task automatic check_resp(input axi_resp_e got, input axi_resp_e exp, input int unsigned n);
  if (got !== exp) begin
    resp_errs++;
    $display("MISMATCH at %0t: entry %0d resp %b, expected %b", $time, n, got, exp);
  end
endtask

task automatic check_rdata(input logic [CFG_DW-1:0] got, input logic [CFG_DW-1:0] exp,
                           input int unsigned n);
  if (got !== exp) begin
    rdata_errs++;
    $display("MISMATCH at %0t: entry %0d rdata %h, expected %h", $time, n, got, exp);
  end
endtask

//////////////////////////////////////////////////
// random data
//////////////////////////////////////////////////

// galois form, right shifting
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
endfunction

// one lfsr step per bit taken
task automatic draw_word(output logic [31:0] w);
  w = '0;
  for (int unsigned i = 0; i < 32; i++) begin
    lfsr = lfsr_step(lfsr);
    w    = {w[30:0], lfsr[0]};
  end
endtask

//////////////////////////////////////////////////
// tcb side
//////////////////////////////////////////////////

// next edge plus drive delay, then any response due now
task automatic tick();
  pend_t p;
  @(posedge sub);
  #10;
  while (pend_q.size() > 0 && pend_q[0].due <= cyc) begin
    p = pend_q.pop_front();
    check_err(err, p.err, p.idx);
    if (p.rd && !p.err) check_rdt(rdt, p.rdt, p.idx);
  end
endtask

// let outstanding responses and the counter update settle
task automatic drain();
  while (pend_q.size() > 0) tick();
  tick();
endtask

task automatic issue_tcb(input int unsigned n);
  entry_t         e;
  logic [31:0]    wd;
  pend_t          p;
  logic [ABW-3:0] w;
  e  = tbl[n];
  wd = '0;
  if (e.op == TCB_WR) draw_word(wd);
  vld = 1'b1;
  wen = (e.op == TCB_WR);
  siz = e.siz;
  adr = e.adr;
  ben = e.ben;
  wdt = wd;
  // memory never stalls, so a request goes every cycle
  check_ready(rdy, 1'b1, "rdy", n);
  while (!rdy) tick();
  // taken on the next edge, response stands from the edge after that
  w     = e.adr[ABW-1:2];
  p.due = cyc + 2;
  p.idx = n;
  p.rd  = (e.op == TCB_RD);
  p.err = e.bad;
  p.rdt = ref_mem[w];
  pend_q.push_back(p);
  if (e.bad) begin
    refused_cnt++;
  end else if (e.op == TCB_WR) begin
    for (int unsigned b = 0; b < DBW / 8; b++) begin
      if (e.ben[b]) ref_mem[w][8*b +: 8] = wd[8*b +: 8];
    end
  end
  tick();
  vld = 1'b0;
endtask

//////////////////////////////////////////////////
// axi4-lite side
//////////////////////////////////////////////////

task automatic axi_write(input int unsigned n, input logic [CFG_AW-1:0] a,
                         input logic [CFG_DW-1:0] d, output axi_resp_e resp);
  awaddr  = a;
  awvalid = 1'b1;
  wdata   = d;
  wstrb   = '1;
  wvalid  = 1'b1;
  bready  = 1'b0;
  // readies follow the valids, look once they have settled
  #1;
  check_ready(awready, 1'b1, "awready", n);
  check_ready(wready, 1'b1, "wready", n);
  tick();
  while (!bvalid) tick();
  awvalid = 1'b0;
  wvalid  = 1'b0;
  resp    = bresp;
  // response must wait one cycle for bready
  tick();
  if (!bvalid || bresp !== resp) begin
    other_errs++;
    $display("error at %0t: write response changed before bready was given", $time);
  end
  bready = 1'b1;
  tick();
  bready = 1'b0;
endtask

task automatic axi_read(input int unsigned n, input logic [CFG_AW-1:0] a,
                        output logic [CFG_DW-1:0] data, output axi_resp_e resp);
  araddr  = a;
  arvalid = 1'b1;
  rready  = 1'b1;
  // idle block takes the address at once
  check_ready(arready, 1'b1, "arready", n);
  tick();
  while (!rvalid) tick();
  arvalid = 1'b0;
  data    = rdata;
  resp    = rresp;
  tick();
  rready = 1'b0;
endtask

`endif

// File: sim/tcb_mem_tb.sv
// tcb memory subsystem testbench
// table driven tcb and axi4-lite stimulus, checked against a reference memory and register model

`default_nettype none

module tcb_mem_tb;

  import tcb_pkg::*;

  localparam int unsigned ABW         = TCB_ABW;
  localparam int unsigned DBW         = TCB_DBW;
  localparam int unsigned NUM         = 32;
  localparam int unsigned RST_CYCLES  = 10;
  // ten cycles per table entry is far more than any entry needs
  localparam int unsigned WDOG_CYCLES = NUM * 10 + RST_CYCLES + 50;

  // table operations, tcb requests and config port accesses
  typedef enum logic [1:0] {
    TCB_WR,
    TCB_RD,
    CFG_WR,
    CFG_RD
  } op_e;

  // one table row, bad means err on tcb or slverr on the config port
  typedef struct packed {
    op_e            op;
    logic [ABW-1:0] adr;
    tcb_siz_e       siz;
    logic [3:0]     ben;
    logic [31:0]    dat;
    logic           bad;
  } entry_t;

  // tcb response still in flight
  typedef struct packed {
    int unsigned    due;
    int unsigned    idx;
    logic           rd;
    logic           err;
    logic [DBW-1:0] rdt;
  } pend_t;

  //////////////////////////////////////////////////
  // dut signals
  //////////////////////////////////////////////////

  logic                  sub;
  logic                  rst_n;
  logic                  vld;
  logic                  rdy;
  logic                  wen;
  tcb_siz_e              siz;
  logic [ABW-1:0]        adr;
  logic [DBW/8-1:0]      ben;
  logic [DBW-1:0]        wdt;
  logic [DBW-1:0]        rdt;
  logic                  err;
  logic [CFG_AW-1:0]     awaddr;
  logic                  awvalid;
  logic                  awready;
  logic [CFG_DW-1:0]     wdata;
  logic [CFG_DW/8-1:0]   wstrb;
  logic                  wvalid;
  logic                  wready;
  axi_resp_e             bresp;
  logic                  bvalid;
  logic                  bready;
  logic [CFG_AW-1:0]     araddr;
  logic                  arvalid;
  logic                  arready;
  logic [CFG_DW-1:0]     rdata;
  axi_resp_e             rresp;
  logic                  rvalid;
  logic                  rready;

  // stimulus, models and bookkeeping
  entry_t         tbl [NUM];
  pend_t          pend_q [$];
  logic [DBW-1:0] ref_mem [2 ** (ABW - 2)];
  logic [ABW-1:0] lim_model   = '1;
  logic           en_model    = 1'b0;
  int unsigned    refused_cnt = 0;
  int unsigned    cyc         = 0;
  logic [31:0]    lfsr        = 32'h986f60ab;
  int unsigned    rdt_errs    = 0;
  int unsigned    err_errs    = 0;
  int unsigned    rdy_errs    = 0;
  int unsigned    resp_errs   = 0;
  int unsigned    rdata_errs  = 0;
  int unsigned    other_errs  = 0;

  `include "tcb_mem_tb_tasks.svh"

  tcb_mem_top #(.ABW(ABW), .DBW(DBW), .GRN(1)) tcb_mem_top_i (.*);

  always #50 sub = ~sub;

  // edge counter, read 10 units after each edge
  always @(posedge sub) cyc <= cyc + 1;

  task automatic set_entry(input int unsigned n, input op_e op, input logic [ABW-1:0] a,
                           input tcb_siz_e s, input logic [3:0] b, input logic [31:0] d,
                           input logic bad);
    tbl[n] = '{op, a, s, b, d, bad};
  endtask

  task automatic load_table();
    // reset state, protection off
    set_entry( 0, CFG_RD, 12'h000, SIZ_WORD, 4'hf, 32'h0, 1'b0);
    set_entry( 1, CFG_RD, 12'h004, SIZ_WORD, 4'hf, 32'h0, 1'b0);
    set_entry( 2, TCB_WR, 12'hff0, SIZ_WORD, 4'hf, 32'h0, 1'b0);
    set_entry( 3, TCB_RD, 12'hff0, SIZ_WORD, 4'hf, 32'h0, 1'b0);
    // back to back words
    set_entry( 4, TCB_WR, 12'h000, SIZ_WORD, 4'hf, 32'h0, 1'b0);
    set_entry( 5, TCB_WR, 12'h004, SIZ_WORD, 4'hf, 32'h0, 1'b0);
    set_entry( 6, TCB_WR, 12'h008, SIZ_WORD, 4'hf, 32'h0, 1'b0);
    set_entry( 7, TCB_RD, 12'h000, SIZ_WORD, 4'hf, 32'h0, 1'b0);
    set_entry( 8, TCB_RD, 12'h004, SIZ_WORD, 4'hf, 32'h0, 1'b0);
    set_entry( 9, TCB_RD, 12'h008, SIZ_WORD, 4'hf, 32'h0, 1'b0);
    // partial byte enables
    set_entry(10, TCB_WR, 12'h005, SIZ_BYTE, 4'h2, 32'h0, 1'b0);
    set_entry(11, TCB_WR, 12'h00a, SIZ_HALF, 4'hc, 32'h0, 1'b0);
    set_entry(12, TCB_WR, 12'h000, SIZ_WORD, 4'h5, 32'h0, 1'b0);
    set_entry(13, TCB_RD, 12'h004, SIZ_WORD, 4'hf, 32'h0, 1'b0);
    set_entry(14, TCB_RD, 12'h008, SIZ_WORD, 4'hf, 32'h0, 1'b0);
    set_entry(15, TCB_RD, 12'h000, SIZ_WORD, 4'hf, 32'h0, 1'b0);
    // protect everything from 0x800 up
    set_entry(16, CFG_WR, 12'h000, SIZ_WORD, 4'hf, 32'h800, 1'b0);
    set_entry(17, CFG_WR, 12'h004, SIZ_WORD, 4'hf, 32'h1, 1'b0);
    set_entry(18, TCB_WR, 12'h800, SIZ_WORD, 4'hf, 32'h0, 1'b1);
    set_entry(19, TCB_WR, 12'hff0, SIZ_WORD, 4'hf, 32'h0, 1'b1);
    set_entry(20, TCB_WR, 12'h7fc, SIZ_WORD, 4'hf, 32'h0, 1'b0);
    set_entry(21, TCB_RD, 12'hff0, SIZ_WORD, 4'hf, 32'h0, 1'b0);
    set_entry(22, TCB_RD, 12'h7fc, SIZ_WORD, 4'hf, 32'h0, 1'b0);
    // misaligned write and read
    set_entry(23, TCB_WR, 12'h002, SIZ_WORD, 4'hf, 32'h0, 1'b1);
    set_entry(24, TCB_RD, 12'h001, SIZ_HALF, 4'hf, 32'h0, 1'b1);
    // counter and illegal config accesses
    set_entry(25, CFG_RD, 12'h008, SIZ_WORD, 4'hf, 32'h0, 1'b0);
    set_entry(26, CFG_WR, 12'h008, SIZ_WORD, 4'hf, 32'h0, 1'b1);
    set_entry(27, CFG_WR, 12'h00c, SIZ_WORD, 4'hf, 32'h0, 1'b1);
    set_entry(28, CFG_RD, 12'h00c, SIZ_WORD, 4'hf, 32'h0, 1'b1);
    set_entry(29, CFG_RD, 12'h008, SIZ_WORD, 4'hf, 32'h0, 1'b0);
    set_entry(30, CFG_RD, 12'h000, SIZ_WORD, 4'hf, 32'h0, 1'b0);
    set_entry(31, CFG_RD, 12'h004, SIZ_WORD, 4'hf, 32'h0, 1'b0);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin : main
    entry_t      e;
    axi_resp_e   resp;
    logic [31:0] data;
    logic [31:0] exp_rd;
    sub     = 1'b0;
    rst_n   = 1'b0;
    vld     = 1'b0;
    wen     = 1'b0;
    siz     = SIZ_WORD;
    adr     = '0;
    ben     = '0;
    wdt     = '0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    load_table();
    repeat (RST_CYCLES) @(posedge sub);
    #10;
    rst_n = 1'b1;
    for (int unsigned i = 0; i < NUM; i++) begin
      e = tbl[i];
      case (e.op)
        TCB_WR, TCB_RD: issue_tcb(i);
        CFG_WR: begin
          // config changes only once the tcb pipe is empty
          drain();
          axi_write(i, e.adr[CFG_AW-1:0], e.dat, resp);
          check_resp(resp, e.bad ? RESP_SLVERR : RESP_OKAY, i);
          if (!e.bad && e.adr[CFG_AW-1:0] == REG_LIMIT) lim_model = e.dat[ABW-1:0];
          if (!e.bad && e.adr[CFG_AW-1:0] == REG_CTRL) en_model = e.dat[0];
        end
        default: begin
          drain();
          axi_read(i, e.adr[CFG_AW-1:0], data, resp);
          check_resp(resp, e.bad ? RESP_SLVERR : RESP_OKAY, i);
          case (cfg_reg_e'(e.adr[CFG_AW-1:0]))
            REG_LIMIT:  exp_rd = 32'(lim_model);
            REG_CTRL:   exp_rd = 32'(en_model);
            REG_ERRCNT: exp_rd = refused_cnt;
            default:    exp_rd = '0;
          endcase
          if (!e.bad) check_rdata(data, exp_rd, i);
        end
      endcase
    end
    drain();
    $display("errors: rdt %0d, err %0d, rdy %0d, resp %0d, rdata %0d, other %0d",
             rdt_errs, err_errs, rdy_errs, resp_errs, rdata_errs, other_errs);
    if (rdt_errs + err_errs + rdy_errs + resp_errs + rdata_errs + other_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // stops a hung run
  initial begin : watchdog
    repeat (WDOG_CYCLES) @(posedge sub);
    $display("timeout: the run did not finish within %0d cycles", WDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule : tcb_mem_tb

`default_nettype wire
